//--- rtl/conv_config.svh
`ifndef CONV_CONFIG_SVH
`define CONV_CONFIG_SVH

// lane counts of the engine.
// one weight lane per output channel, one pixel lane per unit.
`define CONV_UNITS 4
`define CONV_MEMBERS 4

// word widths.
// the product is twice the input width and is widened again by the accumulator.
`define CONV_WORD_IN 8
`define CONV_WORD_ACC 24

// number of register stages in each multiplier.
// must be at least 1.
`define CONV_MUL_LATENCY 2

`endif

//--- rtl/conv_pkg.sv
`default_nettype none

`include "conv_config.svh"

package conv_pkg;

  // word types, all signed two's complement.
  typedef logic signed [`CONV_WORD_IN-1:0] in_word_t;
  typedef logic signed [2*`CONV_WORD_IN-1:0] prod_word_t;
  typedef logic signed [`CONV_WORD_ACC-1:0] acc_word_t;

  // per-beat control bits that travel alongside the data.
  typedef struct packed {
    logic is_cin_last;
    logic is_config;
    logic last;
  } beat_flags_t;

  // one input beat: a weight per member and a pixel per unit.
  typedef struct packed {
    in_word_t [`CONV_MEMBERS-1:0] weights;
    in_word_t [`CONV_UNITS-1:0] pixels;
  } beat_data_t;

  // indexed as [member][unit] in both blocks.
  typedef prod_word_t [`CONV_MEMBERS-1:0][`CONV_UNITS-1:0] prod_block_t;
  typedef acc_word_t [`CONV_MEMBERS-1:0][`CONV_UNITS-1:0] result_block_t;

endpackage

`default_nettype wire

//--- rtl/flag_delay.sv
`default_nettype none

`include "conv_config.svh"

// shift register for the beat valid and flags, as deep as the multipliers.
module flag_delay (
  input  wire                        clk,
  input  wire                        rst,
  input  wire                        run,
  input  wire                        valid_in,
  input  wire conv_pkg::beat_flags_t flags_in,
  output logic                       valid_out,
  output conv_pkg::beat_flags_t      flags_out
);

  logic [`CONV_MUL_LATENCY-1:0]                        valid_q;
  conv_pkg::beat_flags_t [`CONV_MUL_LATENCY-1:0]       flags_q;

  always_ff @(posedge clk) begin
    if (rst) begin
      valid_q <= '0;
    end else if (run) begin
      valid_q[0] <= valid_in;
      for (int i = 1; i < `CONV_MUL_LATENCY; i++) begin
        valid_q[i] <= valid_q[i-1];
      end
    end
  end

  // flags only matter while the matching valid bit is set.
  always_ff @(posedge clk) begin
    if (run) begin
      flags_q[0] <= flags_in;
      for (int i = 1; i < `CONV_MUL_LATENCY; i++) begin
        flags_q[i] <= flags_q[i-1];
      end
    end
  end

  assign valid_out = valid_q[`CONV_MUL_LATENCY-1];
  assign flags_out = flags_q[`CONV_MUL_LATENCY-1];

endmodule

`default_nettype wire

//--- rtl/mul_array.sv
`default_nettype none

`include "conv_config.svh"

// signed multipliers for every member/unit pair.
// each member's weight is shared by all units, each unit's pixel by all members.
module mul_array (
  input  wire                       clk,
  input  wire                       run,
  input  wire conv_pkg::beat_data_t s_data,
  output conv_pkg::prod_block_t     prod
);

  conv_pkg::prod_block_t                          products;
  conv_pkg::prod_block_t [`CONV_MUL_LATENCY-1:0]  pipe;

  //////////////////////////////////////////////////////////////////////
  // multiply
  //////////////////////////////////////////////////////////////////////

  // both operands are sign extended to the product width before multiplying.
  always_comb begin
    for (int m = 0; m < `CONV_MEMBERS; m++) begin
      for (int u = 0; u < `CONV_UNITS; u++) begin
        products[m][u] = $signed(s_data.weights[m]) * $signed(s_data.pixels[u]);
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // pipeline
  //////////////////////////////////////////////////////////////////////

  // retiming these stages into the multiplier is left to synthesis.
  always_ff @(posedge clk) begin
    if (run) begin
      pipe[0] <= products;
      for (int i = 1; i < `CONV_MUL_LATENCY; i++) begin
        pipe[i] <= pipe[i-1];
      end
    end
  end

  assign prod = pipe[`CONV_MUL_LATENCY-1];

endmodule

`default_nettype wire

//--- rtl/acc_array.sv
`default_nettype none

`include "conv_config.svh"

// one accumulator per member/unit pair, plus the output data register.
module acc_array (
  input  wire                        clk,
  input  wire                        rst,
  input  wire                        run,
  input  wire                        acc_valid,
  input  wire                        acc_bypass,
  input  wire                        acc_emit,
  input  wire conv_pkg::prod_block_t prod,
  output conv_pkg::result_block_t    m_data
);

  conv_pkg::result_block_t sum_q;
  conv_pkg::result_block_t sum_next;

  // an empty slot adds zero, so a partial sum survives pipeline bubbles.
  always_comb begin
    conv_pkg::acc_word_t addend;
    for (int m = 0; m < `CONV_MEMBERS; m++) begin
      for (int u = 0; u < `CONV_UNITS; u++) begin
        if (acc_valid) begin
          addend = $signed(prod[m][u]);
        end else begin
          addend = '0;
        end
        if (acc_bypass) begin
          sum_next[m][u] = addend;
        end else begin
          sum_next[m][u] = sum_q[m][u] + addend;
        end
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // sum and output registers
  //////////////////////////////////////////////////////////////////////

  // cleared sums let the first beat after reset start a fresh total.
  always_ff @(posedge clk) begin
    if (rst) begin
      sum_q <= '0;
    end else if (run) begin
      sum_q <= sum_next;
    end
  end

  // the finished sum is captured here and held until the next emit.
  always_ff @(posedge clk) begin
    if (run && acc_emit) begin
      m_data <= sum_next;
    end
  end

endmodule

`default_nettype wire

//--- rtl/conv_control.sv
`default_nettype none

// control path of the engine.
// one global enable freezes the whole pipeline while a result waits for m_ready.
module conv_control (
  input  wire                        clk,
  input  wire                        rst,
  input  wire                        s_valid,
  input  wire                        m_ready,
  input  wire conv_pkg::beat_flags_t s_flags,
  output logic                       s_ready,
  output logic                       run,
  output logic                       acc_valid,
  output logic                       acc_bypass,
  output logic                       acc_emit,
  output logic                       m_valid,
  output logic                       m_last
);

  logic                  s_accept;
  logic                  valid_d;
  conv_pkg::beat_flags_t flags_d;
  logic                  bypass_q;

  // stall only while a result is held and the sink is not taking it.
  assign run      = !(m_valid && !m_ready);
  assign s_ready  = run;
  assign s_accept = s_valid && s_ready;

  // line the beat flags up with the products leaving the multipliers.
  flag_delay u_flag_delay (
    .clk       (clk),
    .rst       (rst),
    .run       (run),
    .valid_in  (s_accept),
    .flags_in  (s_flags),
    .valid_out (valid_d),
    .flags_out (flags_d)
  );

  //////////////////////////////////////////////////////////////////////
  // accumulator control
  //////////////////////////////////////////////////////////////////////

  assign acc_valid  = valid_d;
  assign acc_emit   = valid_d && (flags_d.is_cin_last || flags_d.is_config);
  assign acc_bypass = bypass_q;

  // a beat that closed a sum, or a config beat, makes the next beat start fresh.
  // config beats are expected on a sum boundary, so each one emits its raw products.
  always_ff @(posedge clk) begin
    if (rst) begin
      bypass_q <= 1'b0;
    end else if (run && valid_d) begin
      bypass_q <= flags_d.is_cin_last || flags_d.is_config;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // output handshake
  //////////////////////////////////////////////////////////////////////

  // run is high whenever m_valid is low or a handshake happens, so
  // loading acc_emit here also drops m_valid after a handshake.
  always_ff @(posedge clk) begin
    if (rst) begin
      m_valid <= 1'b0;
      m_last  <= 1'b0;
    end else if (run) begin
      m_valid <= acc_emit;
      m_last  <= acc_emit && flags_d.last;
    end
  end

endmodule

`default_nettype wire

//--- rtl/conv_engine.sv
`default_nettype none

// 1x1 convolution engine.
// every member/unit pair multiplies its weight and pixel, and the products
// are summed over the input-channel beats until a beat flagged is_cin_last.
module conv_engine (
  input  wire                       clk,
  input  wire                       rst,
  input  wire                       s_valid,
  output logic                      s_ready,
  input  wire conv_pkg::beat_flags_t s_flags,
  input  wire conv_pkg::beat_data_t  s_data,
  output logic                      m_valid,
  input  wire                       m_ready,
  output logic                      m_last,
  output conv_pkg::result_block_t   m_data
);

  logic                  run;
  logic                  acc_valid;
  logic                  acc_bypass;
  logic                  acc_emit;
  conv_pkg::prod_block_t prod;

  //////////////////////////////////////////////////////////////////////
  // control path
  //////////////////////////////////////////////////////////////////////

  conv_control u_control (
    .clk        (clk),
    .rst        (rst),
    .s_valid    (s_valid),
    .m_ready    (m_ready),
    .s_flags    (s_flags),
    .s_ready    (s_ready),
    .run        (run),
    .acc_valid  (acc_valid),
    .acc_bypass (acc_bypass),
    .acc_emit   (acc_emit),
    .m_valid    (m_valid),
    .m_last     (m_last)
  );

  //////////////////////////////////////////////////////////////////////
  // data path
  //////////////////////////////////////////////////////////////////////

  mul_array u_mul_array (
    .clk    (clk),
    .run    (run),
    .s_data (s_data),
    .prod   (prod)
  );

  acc_array u_acc_array (
    .clk        (clk),
    .rst        (rst),
    .run        (run),
    .acc_valid  (acc_valid),
    .acc_bypass (acc_bypass),
    .acc_emit   (acc_emit),
    .prod       (prod),
    .m_data     (m_data)
  );

endmodule

`default_nettype wire

//--- bench/tb_conv_engine.sv
`default_nettype none

`include "conv_config.svh"

module tb_conv_engine;

  logic                    clk;
  logic                    rst;
  logic                    s_valid;
  logic                    s_ready;
  conv_pkg::beat_flags_t   s_flags;
  conv_pkg::beat_data_t    s_data;
  logic                    m_valid;
  logic                    m_ready;
  logic                    m_last;
  conv_pkg::result_block_t m_data;

  // beats to send and results to expect, in file order.
  conv_pkg::beat_flags_t   beat_flags_q [$];
  conv_pkg::beat_data_t    beat_data_q [$];
  conv_pkg::result_block_t exp_data_q [$];
  logic                    exp_last_q [$];
  logic [8*16-1:0]         exp_name_q [$];

  logic [31:0] lfsr_state;
  int          mismatches;
  int          failures;
  int          cycles;

  conv_engine uut (.*);

  initial begin
    clk = 1'b0;
    forever begin
      #10 clk = ~clk;
    end
  end

  // galois lfsr, shifted right once for every bit handed out.
  function automatic logic random_bit();
    logic b;
    b = lfsr_state[0];
    lfsr_state = lfsr_state >> 1;
    if (b) begin
      lfsr_state = lfsr_state ^ 32'hd000_0001;
    end
    return b;
  endfunction

  //////////////////////////////////////////////////////////////////////
  // test data
  //////////////////////////////////////////////////////////////////////

  // B records are beats, E records are one member row of an expected block.
  task automatic read_testdata();
    int                      fd;
    int                      code;
    byte                     tag;
    logic [8*128-1:0]        skip_buf;
    logic [3:0]              cin_last;
    logic [3:0]              is_config;
    logic [3:0]              last;
    logic [7:0]              pix [4];
    logic [7:0]              wgt [4];
    logic [8*16-1:0]         name;
    int                      member;
    logic [23:0]             row [4];
    conv_pkg::beat_flags_t   flags;
    conv_pkg::beat_data_t    data;
    conv_pkg::result_block_t block;
    fd = $fopen("bench/conv_testdata.txt", "r");
    if (fd == 0) begin
      $display("could not open the test data file");
      failures++;
      return;
    end
    block = '0;
    while (!$feof(fd)) begin
      code = $fscanf(fd, " %c", tag);
      if (code != 1) begin
        break;
      end
      if (tag == "#") begin
        code = $fgets(skip_buf, fd);
      end else if (tag == "B") begin
        code = $fscanf(fd, "%h %h %h %h %h %h %h %h %h %h %h", cin_last, is_config, last,
                       pix[0], pix[1], pix[2], pix[3], wgt[0], wgt[1], wgt[2], wgt[3]);
        flags.is_cin_last = cin_last[0];
        flags.is_config   = is_config[0];
        flags.last        = last[0];
        for (int i = 0; i < 4; i++) begin
          data.pixels[i]  = pix[i];
          data.weights[i] = wgt[i];
        end
        beat_flags_q.push_back(flags);
        beat_data_q.push_back(data);
      end else if (tag == "E") begin
        code = $fscanf(fd, "%s %h %d %h %h %h %h", name, last, member,
                       row[0], row[1], row[2], row[3]);
        for (int u = 0; u < `CONV_UNITS; u++) begin
          block[member][u] = row[u];
        end
        // the last member row completes the block.
        if (member == `CONV_MEMBERS - 1) begin
          exp_data_q.push_back(block);
          exp_last_q.push_back(last[0]);
          exp_name_q.push_back(name);
        end
      end else begin
        $display("unknown record tag in the test data");
        failures++;
      end
    end
    $fclose(fd);
  endtask

  task automatic check_result();
    conv_pkg::result_block_t expected;
    logic                    expected_last;
    logic [8*16-1:0]         name;
    if (exp_data_q.size() == 0) begin
      $display("a result arrived after every expected result was already seen");
      failures++;
      return;
    end
    expected      = exp_data_q.pop_front();
    expected_last = exp_last_q.pop_front();
    name          = exp_name_q.pop_front();
    for (int m = 0; m < `CONV_MEMBERS; m++) begin
      if (m_data[m] !== expected[m]) begin
        $display("mismatch %0s member %0d: expected %h, actual %h", name, m,
                 expected[m], m_data[m]);
        mismatches++;
      end
    end
    if (m_last !== expected_last) begin
      $display("mismatch last: expected %b, actual %b", expected_last, m_last);
      mismatches++;
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // stimulus and checks
  //////////////////////////////////////////////////////////////////////

  initial begin : main
    conv_pkg::result_block_t held_data;
    logic                    held;
    logic                    held_last;
    int                      beat_idx;
    int                      results;
    int                      limit;
    rst        = 1'b1;
    s_valid    = 1'b0;
    s_flags    = '0;
    s_data     = '0;
    m_ready    = 1'b0;
    lfsr_state = 32'he7cd_e98e;
    mismatches = 0;
    failures   = 0;
    cycles     = 0;
    held       = 1'b0;
    held_data  = '0;
    held_last  = 1'b0;
    beat_idx   = 0;
    results    = 0;
    read_testdata();
    limit = 20 * beat_data_q.size() + 100;

    repeat (4) @(posedge clk);
    #2;
    rst = 1'b0;
    @(negedge clk);
    if (m_valid !== 1'b0 || s_ready !== 1'b1) begin
      $display("after reset m_valid is not low or s_ready is not high");
      failures++;
    end

    // inputs change 2 units after the rising edge, outputs are sampled at the falling edge.
    while (exp_data_q.size() > 0) begin
      @(posedge clk);
      #2;
      s_valid = random_bit();
      if (beat_idx < beat_data_q.size()) begin
        s_flags = beat_flags_q[beat_idx];
        s_data  = beat_data_q[beat_idx];
      end else begin
        s_valid = 1'b0;
      end
      m_ready = random_bit();
      @(negedge clk);
      cycles++;
      if (held && m_valid !== 1'b1) begin
        $display("m_valid dropped while m_ready was low");
        failures++;
      end else if (held && (m_data !== held_data || m_last !== held_last)) begin
        $display("mismatch backpressure: expected %h, actual %h", held_data, m_data);
        mismatches++;
      end
      held      = m_valid && !m_ready;
      held_data = m_data;
      held_last = m_last;
      if (s_valid && s_ready) begin
        beat_idx++;
      end
      if (m_valid && m_ready) begin
        check_result();
        results++;
      end
      if (cycles >= limit) begin
        $display("timeout after %0d cycles with %0d results received", cycles, results);
        failures++;
        break;
      end
    end

    // nothing more may come out once every expected result has been seen.
    @(posedge clk);
    #2;
    s_valid = 1'b0;
    m_ready = 1'b1;
    repeat (8) begin
      @(negedge clk);
      if (m_valid) begin
        $display("an extra result appeared after the last expected one");
        failures++;
      end
    end
    if (beat_idx != beat_data_q.size()) begin
      $display("only %0d of %0d beats were accepted", beat_idx, beat_data_q.size());
      failures++;
    end

    $display("mismatches: %0d, other failures: %0d", mismatches, failures);
    if (mismatches == 0 && failures == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- bench/conv_testdata.txt
# B cin_last config last, pixels 0..3, weights 0..3 (8-bit hex)
# E test last member, expected sums of units 0..3 for that member (24-bit hex)
B 0 0 0 01 02 03 04 01 02 03 04
B 0 0 0 01 01 01 01 0a 14 1e 28
B 1 0 0 00 00 00 10 01 01 01 01
E cin_sum 0 0 00000b 00000c 00000d 00001e
E cin_sum 0 1 000016 000018 00001a 00002c
E cin_sum 0 2 000021 000024 000027 00003a
E cin_sum 0 3 00002c 000030 000034 000048
B 0 1 0 03 ff 00 05 02 fe 01 00
E config 0 0 000006 fffffe 000000 00000a
E config 0 1 fffffa 000002 000000 fffff6
E config 0 2 000003 ffffff 000000 000005
E config 0 3 000000 000000 000000 000000
B 0 1 0 01 01 01 01 07 07 07 07
E config 0 0 000007 000007 000007 000007
E config 0 1 000007 000007 000007 000007
E config 0 2 000007 000007 000007 000007
E config 0 3 000007 000007 000007 000007
B 0 0 0 01 02 03 04 01 01 01 01
B 1 0 0 01 01 01 01 01 01 01 01
E config 0 0 000002 000003 000004 000005
E config 0 1 000002 000003 000004 000005
E config 0 2 000002 000003 000004 000005
E config 0 3 000002 000003 000004 000005
B 0 0 1 80 80 ff 7f 80 ff 01 80
B 0 0 1 80 80 ff 7f 80 ff 01 80
B 0 0 1 80 80 ff 7f 80 ff 01 80
B 0 0 1 80 80 ff 7f 80 ff 01 80
B 0 0 1 80 80 ff 7f 80 ff 01 80
B 0 0 1 80 80 ff 7f 80 ff 01 80
B 0 0 1 80 80 ff 7f 80 ff 01 80
B 1 0 1 80 80 ff 7f 80 ff 01 80
E signed 1 0 020000 020000 000400 fe0400
E signed 1 1 000400 000400 000008 fffc08
E signed 1 2 fffc00 fffc00 fffff8 0003f8
E signed 1 3 020000 020000 000400 fe0400

//--- sources.f
+incdir+rtl
rtl/conv_pkg.sv
rtl/flag_delay.sv
rtl/mul_array.sv
rtl/acc_array.sv
rtl/conv_control.sv
rtl/conv_engine.sv
bench/tb_conv_engine.sv

//--- run_sim.sh
#!/bin/sh
# Builds the testbench with Verilator and runs it from the project root.
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -Wno-fatal -f sources.f --top-module tb_conv_engine \
  -o sim_conv > build.log 2>&1 || { cat build.log; exit 1; }
./obj_dir/sim_conv > sim.log 2>&1 ; cat sim.log
grep -qx "Finished with no errors" sim.log && exit 0 || exit 1
